// ==== Makefile ====
# Verilator build and run for the scan doubler testbench

VERILATOR ?= verilator
TOP       ?= scan2x_tb
BUILD_DIR ?= build
FILELIST  ?= src.f
SRCS      ?= $(shell cat $(FILELIST))

VFLAGS ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the simulation, exit status gives the result"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "  help   show this list"

$(BUILD_DIR)/$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) \
		-o $(TOP) -f $(FILELIST)

test: $(BUILD_DIR)/$(TOP)
	./$(BUILD_DIR)/$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== logic/scan2x_line_buffer.sv ====
// Two-bank line memory. One bank takes the incoming line while the other
// is read back at the doubled rate. Read data is registered, one clock
// after the pxl2_cen tick that samples rd_addr.

`timescale 1ns/100ps
`default_nettype none

module scan2x_line_buffer #(
    parameter int COLORW = 4,
    parameter int HLEN   = 64
) (
    input  wire logic                  clk_sys,
    input  wire logic                  pxl_cen,
    input  wire logic                  pxl2_cen,
    input  wire logic [3*COLORW-1:0]   base_pxl,
    scan_if.buffer                     ctl,
    output logic      [3*COLORW-1:0]   rd_pxl
);

    localparam int DW = 3 * COLORW;

    logic [DW-1:0] mem [0:1][0:HLEN-1];
    logic          rd_bank;

    // Read from the bank not being written
    assign rd_bank = ~ctl.wr_bank;

    // Input side, one word per input pixel
    always_ff @(posedge clk_sys) begin
        if (pxl_cen) begin
            mem[ctl.wr_bank][ctl.wr_addr] <= base_pxl;
        end
    end

    // Output side at the doubled pixel rate
    always_ff @(posedge clk_sys) begin
        if (pxl2_cen) begin
            rd_pxl <= mem[rd_bank][ctl.rd_addr];
        end
    end

endmodule

`default_nettype wire

// ==== logic/scan2x_line_fsm.sv ====
// Line sequencing for the scan doubler.
// Display starts only after two line starts, so the first shown line
// is always complete. The read bank is the one not being written.

`timescale 1ns/100ps
`default_nettype none

module scan2x_line_fsm (
    input  wire logic clk_sys,
    input  wire logic reset,
    scan_if.fsm       ctl
);

    typedef enum logic [1:0] {
        WAIT_SYNC   = 2'd0,
        FILL        = 2'd1,
        SHOW_FIRST  = 2'd2,
        SHOW_REPEAT = 2'd3
    } state_e;

    state_e state;
    state_e state_nxt;

    always_comb begin
        state_nxt = state;
        case (state)
            WAIT_SYNC: begin
                if (ctl.line_start) state_nxt = FILL;
            end
            // One full line goes into the buffer before anything is shown
            FILL: begin
                if (ctl.line_start) state_nxt = SHOW_FIRST;
            end
            SHOW_FIRST: begin
                if (ctl.line_start) begin
                    state_nxt = SHOW_FIRST;
                end else if (ctl.rd_wrap) begin
                    state_nxt = SHOW_REPEAT;
                end
            end
            SHOW_REPEAT: begin
                if (ctl.line_start) state_nxt = SHOW_FIRST;
            end
            default: state_nxt = WAIT_SYNC;
        endcase
    end

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            state       <= WAIT_SYNC;
            ctl.wr_bank <= 1'b0;
        end else begin
            state <= state_nxt;
            // Ping-pong on every input line
            if (ctl.line_start) begin
                ctl.wr_bank <= ~ctl.wr_bank;
            end
        end
    end

    assign ctl.show     = (state == SHOW_FIRST) || (state == SHOW_REPEAT);
    assign ctl.dim_line = state == SHOW_REPEAT;

endmodule

`default_nettype wire

// ==== logic/scan2x_line_timer.sv ====
// Write and read position counters for the scan doubler.
// The line start is taken from the rising edge of hs sampled on pxl_cen.
// pxl_cen must coincide with a pxl2_cen tick, as both counters clear together.
// HLEN includes blanking and must exceed HS_LEN.

`timescale 1ns/100ps
`default_nettype none

module scan2x_line_timer
    import scan2x_pkg::*;
#(
    parameter int HLEN = 64
) (
    input  wire logic clk_sys,
    input  wire logic reset,
    input  wire logic pxl_cen,
    input  wire logic pxl2_cen,
    input  wire logic hs,
    scan_if.timer     ctl,
    output logic      hs_raw
);

    localparam int AW = $clog2(HLEN);

    logic hs_q;
    logic rd_last;
    logic wr_last;

    // Input sync history, one sample per input pixel
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            hs_q <= 1'b0;
        end else if (pxl_cen) begin
            hs_q <= hs;
        end
    end

    assign ctl.line_start = pxl_cen & hs & ~hs_q;

    assign wr_last = ctl.wr_addr == AW'(HLEN - 1);
    assign rd_last = ctl.rd_addr == AW'(HLEN - 1);

    // Line start has priority over the end-of-line wrap
    assign ctl.rd_wrap = pxl2_cen & rd_last & ~ctl.line_start;

    // Write position at the input pixel rate
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            ctl.wr_addr <= '0;
        end else if (pxl_cen) begin
            if (ctl.line_start || wr_last) begin
                ctl.wr_addr <= '0;
            end else begin
                ctl.wr_addr <= ctl.wr_addr + 1'b1;
            end
        end
    end

    // Read position at twice the rate, so one input line gives two output lines
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            ctl.rd_addr <= '0;
        end else if (pxl2_cen) begin
            if (ctl.line_start || rd_last) begin
                ctl.rd_addr <= '0;
            end else begin
                ctl.rd_addr <= ctl.rd_addr + 1'b1;
            end
        end
    end

    // Sync at the start of every output line, before buffer latency
    assign hs_raw = ctl.rd_addr < AW'(HS_LEN);

endmodule

`default_nettype wire

// ==== logic/scan2x_pkg.sv ====
// Constants and types shared by the scan doubler blocks.
// OUT_W is fixed at 8 bits per channel on the output side.
// HS_LEN must stay below the line length HLEN set at the top level.

`default_nettype none

package scan2x_pkg;

    // Output channel width after color extension
    localparam int unsigned OUT_W = 8;

    // Doubled sync width in pxl2_cen ticks
    localparam int unsigned HS_LEN = 8;

    // Scanline dimming applied to the repeated output line
    typedef enum logic [1:0] {
        SL_NONE = 2'd0,  // no dimming
        SL_25   = 2'd1,  // value minus a quarter
        SL_50   = 2'd2,  // half value
        SL_75   = 2'd3   // quarter value
    } sl_mode_e;

endpackage

`default_nettype wire

// ==== logic/scan2x_shader.sv ====
// Output stage. Each channel is widened to OUT_W by bit replication from
// the top, then dimmed on repeat lines according to sl_mode.
// Sync and line flags are held back one pxl2_cen tick to match the buffer
// read. COLORW must lie in 3..8.

`timescale 1ns/100ps
`default_nettype none

module scan2x_shader
    import scan2x_pkg::*;
#(
    parameter int COLORW = 4
) (
    input  wire logic                 clk_sys,
    input  wire logic                 reset,
    input  wire logic                 pxl2_cen,
    input  wire logic [3*COLORW-1:0]  rd_pxl,
    input  wire logic                 hs_raw,
    input  wire logic                 dim_line,
    input  wire logic                 show,
    input  wire sl_mode_e             sl_mode,
    output logic      [OUT_W-1:0]     scan2x_r,
    output logic      [OUT_W-1:0]     scan2x_g,
    output logic      [OUT_W-1:0]     scan2x_b,
    output logic                      scan2x_hs
);

    logic hs_d;
    logic dim_d;
    logic show_d;

    // Repeat the input bits from the MSB down until OUT_W bits are filled
    function automatic logic [OUT_W-1:0] extend(input logic [COLORW-1:0] a);
        logic [OUT_W-1:0] v;
        for (int i = 0; i < OUT_W; i++) begin
            v[OUT_W-1-i] = a[COLORW-1-(i % COLORW)];
        end
        return v;
    endfunction

    function automatic logic [OUT_W-1:0] shade(
        input logic [OUT_W-1:0] v,
        input logic             dim,
        input sl_mode_e         mode
    );
        logic [OUT_W-1:0] s;
        s = v;
        if (dim) begin
            case (mode)
                SL_25:   s = v - (v >> 2);
                SL_50:   s = v >> 1;
                SL_75:   s = v >> 2;
                default: s = v;
            endcase
        end
        return s;
    endfunction

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            hs_d      <= 1'b0;
            dim_d     <= 1'b0;
            show_d    <= 1'b0;
            scan2x_hs <= 1'b0;
            scan2x_r  <= '0;
            scan2x_g  <= '0;
            scan2x_b  <= '0;
        end else if (pxl2_cen) begin
            // Same tick as the buffer samples rd_addr
            hs_d      <= hs_raw;
            dim_d     <= dim_line;
            show_d    <= show;
            scan2x_hs <= hs_d;
            if (show_d) begin
                scan2x_r <= shade(extend(rd_pxl[3*COLORW-1 -: COLORW]), dim_d, sl_mode);
                scan2x_g <= shade(extend(rd_pxl[2*COLORW-1 -: COLORW]), dim_d, sl_mode);
                scan2x_b <= shade(extend(rd_pxl[COLORW-1:0]), dim_d, sl_mode);
            end else begin
                scan2x_r <= '0;
                scan2x_g <= '0;
                scan2x_b <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/scan2x_top.sv ====
// Low-memory scan doubler with 8-bit color extension.
// pxl_cen must coincide with every second pxl2_cen; there is no back-pressure.
// HLEN is the full input line length including blanking.
// Output appears two line starts after reset, one input line behind.

`timescale 1ns/100ps
`default_nettype none

module scan2x_top
    import scan2x_pkg::*;
#(
    parameter int COLORW = 4,
    parameter int HLEN   = 64
) (
    input  wire logic                 clk_sys,
    input  wire logic                 reset,
    input  wire logic                 pxl_cen,
    input  wire logic                 pxl2_cen,
    input  wire logic [3*COLORW-1:0]  base_pxl,   // red in the top bits
    input  wire logic                 hs,
    input  wire sl_mode_e             sl_mode,
    output logic      [OUT_W-1:0]     scan2x_r,
    output logic      [OUT_W-1:0]     scan2x_g,
    output logic      [OUT_W-1:0]     scan2x_b,
    output logic                      scan2x_hs
);

    logic                hs_raw;
    logic [3*COLORW-1:0] rd_pxl;

    scan_if #(.HLEN(HLEN)) ctl ();

    scan2x_line_timer #(.HLEN(HLEN)) u_timer (
        .clk_sys  ( clk_sys  ),
        .reset    ( reset    ),
        .pxl_cen  ( pxl_cen  ),
        .pxl2_cen ( pxl2_cen ),
        .hs       ( hs       ),
        .ctl      ( ctl      ),
        .hs_raw   ( hs_raw   )
    );

    scan2x_line_fsm u_fsm (
        .clk_sys  ( clk_sys  ),
        .reset    ( reset    ),
        .ctl      ( ctl      )
    );

    scan2x_line_buffer #(.COLORW(COLORW), .HLEN(HLEN)) u_buffer (
        .clk_sys  ( clk_sys  ),
        .pxl_cen  ( pxl_cen  ),
        .pxl2_cen ( pxl2_cen ),
        .base_pxl ( base_pxl ),
        .ctl      ( ctl      ),
        .rd_pxl   ( rd_pxl   )
    );

    scan2x_shader #(.COLORW(COLORW)) u_shader (
        .clk_sys   ( clk_sys      ),
        .reset     ( reset        ),
        .pxl2_cen  ( pxl2_cen     ),
        .rd_pxl    ( rd_pxl       ),
        .hs_raw    ( hs_raw       ),
        .dim_line  ( ctl.dim_line ),
        .show      ( ctl.show     ),
        .sl_mode   ( sl_mode      ),
        .scan2x_r  ( scan2x_r     ),
        .scan2x_g  ( scan2x_g     ),
        .scan2x_b  ( scan2x_b     ),
        .scan2x_hs ( scan2x_hs    )
    );

endmodule

`default_nettype wire

// ==== logic/scan_if.sv ====
// Line control and buffer addressing between the steering blocks and the
// line buffer. Addresses are sized for HLEN entries per bank.

`timescale 1ns/100ps
`default_nettype none

interface scan_if #(
    parameter int HLEN = 64
) ();

    localparam int AW = $clog2(HLEN);

    // Buffer positions
    logic [AW-1:0] wr_addr;
    logic [AW-1:0] rd_addr;

    // Line events, single cycle
    logic          line_start;
    logic          rd_wrap;

    // Line state
    logic          wr_bank;
    logic          dim_line;
    logic          show;

    modport timer (
        output wr_addr, rd_addr, line_start, rd_wrap
    );

    modport fsm (
        input  line_start, rd_wrap,
        output wr_bank, dim_line, show
    );

    modport buffer (
        input  wr_addr, rd_addr, wr_bank
    );

endinterface

`default_nettype wire

// ==== src.f ====
logic/scan2x_pkg.sv
logic/scan_if.sv
logic/scan2x_line_timer.sv
logic/scan2x_line_fsm.sv
logic/scan2x_line_buffer.sv
logic/scan2x_shader.sv
logic/scan2x_top.sv
tests/scan2x_sva.sv
tests/scan2x_tb.sv

// ==== tests/scan2x_sva.sv ====
// Concurrent checks on the scan2x_top ports, attached with bind.
// Pulse width is counted in pxl2_cen ticks; checks pause while reset is high.

`timescale 1ns/100ps
`default_nettype none

module scan2x_sva import scan2x_pkg::*; (
    input wire logic             clk_sys,
    input wire logic             reset,
    input wire logic             pxl2_cen,
    input wire logic [OUT_W-1:0] scan2x_r,
    input wire logic [OUT_W-1:0] scan2x_g,
    input wire logic [OUT_W-1:0] scan2x_b,
    input wire logic             scan2x_hs
);

    int hs_run;

    // High samples of scan2x_hs seen so far in the current pulse
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            hs_run <= 0;
        end else if (pxl2_cen) begin
            hs_run <= scan2x_hs ? hs_run + 1 : 0;
        end
    end

    hs_low_in_reset: assert property (@(posedge clk_sys)
        $past(reset) && reset |-> !scan2x_hs)
        else $error("scan2x_hs high during reset");

    out_on_tick: assert property (@(posedge clk_sys) disable iff (reset)
        !$past(pxl2_cen) |-> $stable({scan2x_r, scan2x_g, scan2x_b, scan2x_hs}))
        else $error("outputs changed without a pxl2_cen tick");

    hs_not_long: assert property (@(posedge clk_sys) disable iff (reset)
        pxl2_cen && scan2x_hs |-> hs_run < int'(HS_LEN))
        else $error("scan2x_hs pulse longer than HS_LEN");

    hs_not_short: assert property (@(posedge clk_sys) disable iff (reset)
        pxl2_cen && !scan2x_hs && hs_run != 0 |-> hs_run == int'(HS_LEN))
        else $error("scan2x_hs pulse shorter than HS_LEN");

endmodule

bind scan2x_top scan2x_sva i_sva (
    .clk_sys   ( clk_sys   ),
    .reset     ( reset     ),
    .pxl2_cen  ( pxl2_cen  ),
    .scan2x_r  ( scan2x_r  ),
    .scan2x_g  ( scan2x_g  ),
    .scan2x_b  ( scan2x_b  ),
    .scan2x_hs ( scan2x_hs )
);

`default_nettype wire

// ==== tests/scan2x_tb.sv ====
// Testbench for scan2x_top with COLORW 4 and HLEN 64.
// Strobes, sync and pixels are driven on the falling edge, outputs are sampled
// on the falling edge after each pxl2_cen tick. Input lines are exactly HLEN long.
// Stops with $fatal at the first mismatch or timeout.

`timescale 1ns/100ps
`default_nettype none

module scan2x_tb import scan2x_pkg::*; ();

    localparam int COLORW     = 4;
    localparam int HLEN       = 64;
    localparam int DW         = 3 * COLORW;
    localparam int SEED       = 33;
    localparam int IDLE_TICKS = 40;  // puts the first line start away from an output sync
    localparam int SYNC_TICKS = 4;
    localparam int MODE_TICK  = 2;   // sl_mode moves while hs is high
    localparam int MIN_SHOWN  = 60;

    logic              clk_sys;
    logic              reset;
    logic              pxl_cen;
    logic              pxl2_cen;
    logic [DW-1:0]     base_pxl;
    logic              hs;
    sl_mode_e          sl_mode;
    logic [OUT_W-1:0]  scan2x_r;
    logic [OUT_W-1:0]  scan2x_g;
    logic [OUT_W-1:0]  scan2x_b;
    logic              scan2x_hs;

    // Every pixel driven since the last reset, and where each line starts
    logic [DW-1:0]     pix_stream[$];
    int                starts[$];
    int                line_cnt;

    // Output side bookkeeping
    int                out_tick;
    int                seen_line;
    int                rises_in_line;
    int                last_rise_tick;
    int                shown_lines;

    scan2x_top #(.COLORW(COLORW), .HLEN(HLEN)) i_dut (
        .clk_sys   ( clk_sys   ),
        .reset     ( reset     ),
        .pxl_cen   ( pxl_cen   ),
        .pxl2_cen  ( pxl2_cen  ),
        .base_pxl  ( base_pxl  ),
        .hs        ( hs        ),
        .sl_mode   ( sl_mode   ),
        .scan2x_r  ( scan2x_r  ),
        .scan2x_g  ( scan2x_g  ),
        .scan2x_b  ( scan2x_b  ),
        .scan2x_hs ( scan2x_hs )
    );

    always #5 clk_sys = ~clk_sys;

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic compare_value(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        if (exp !== act) begin
            $display("error: %s expected 0x%0h got 0x%0h", name, exp, act);
            report_failure("first mismatch reached");
        end
    endtask

    // Widen by repeating the channel bits, then dim on the repeat line
    function automatic logic [3*OUT_W-1:0] expected_pixel(input logic [DW-1:0] pix,
                                                          input bit rep_line,
                                                          input sl_mode_e mode);
        logic [3*OUT_W-1:0] res;
        int c;
        int wide;
        int nbits;
        int v;
        res = '0;
        for (int ch = 0; ch < 3; ch++) begin
            c     = int'(pix[ch*COLORW +: COLORW]);
            wide  = 0;
            nbits = 0;
            while (nbits < OUT_W) begin
                wide  = (wide << COLORW) | c;
                nbits = nbits + COLORW;
            end
            v = wide >> (nbits - OUT_W);
            if (rep_line) begin
                case (mode)
                    SL_25:   v = v - v / 4;
                    SL_50:   v = v / 2;
                    SL_75:   v = v / 4;
                    default: v = v;
                endcase
            end
            res[ch*OUT_W +: OUT_W] = v[OUT_W-1:0];
        end
        return res;
    endfunction

    // One input pixel is four clocks, pxl2_cen on the first and third
    task automatic drive_pixel(input logic sync, input logic [DW-1:0] pix);
        pix_stream.push_back(pix);
        pxl_cen  = 1'b1;
        pxl2_cen = 1'b1;
        hs       = sync;
        base_pxl = pix;
        @(negedge clk_sys);
        pxl_cen  = 1'b0;
        pxl2_cen = 1'b0;
        @(negedge clk_sys);
        pxl2_cen = 1'b1;
        @(negedge clk_sys);
        pxl2_cen = 1'b0;
        @(negedge clk_sys);
    endtask

    task automatic apply_reset();
        reset    = 1'b1;
        pxl_cen  = 1'b0;
        pxl2_cen = 1'b0;
        hs       = 1'b0;
        repeat (10) @(negedge clk_sys);
        pix_stream.delete();
        starts.delete();
        line_cnt = 0;
        reset    = 1'b0;
    endtask

    task automatic run_idle(input int n);
        repeat (n) drive_pixel(1'b0, DW'($urandom));
    endtask

    task automatic run_line(input sl_mode_e mode);
        for (int i = 0; i < HLEN; i++) begin
            if (i == 0) begin
                starts.push_back(pix_stream.size());
                line_cnt++;
            end
            if (i == MODE_TICK) sl_mode = mode;
            drive_pixel(i < SYNC_TICKS, DW'($urandom));
        end
    endtask

    // Falling edge after the next pxl2_cen tick; ok is low if reset was seen
    task automatic next_out_tick(output bit ok);
        bit got;
        got = 1'b0;
        ok  = 1'b0;
        for (int n = 0; n < 16; n++) begin
            @(posedge clk_sys);
            if (reset) break;
            if (pxl2_cen) begin
                got = 1'b1;
                break;
            end
        end
        if (got) begin
            @(negedge clk_sys);
            out_tick++;
            ok = 1'b1;
        end else if (!reset) begin
            report_failure("timeout: no pxl2_cen tick within 16 clocks");
        end
    endtask

    task automatic wait_rise();
        bit   ok;
        bit   found;
        logic prev;
        found = 1'b0;
        prev  = scan2x_hs === 1'b1;
        for (int n = 0; n < 4000 && !found; n++) begin
            next_out_tick(ok);
            if (!ok) begin
                prev          = 1'b0;
                seen_line     = 0;
                rises_in_line = 0;
            end else begin
                found = scan2x_hs && !prev;
                prev  = scan2x_hs;
            end
        end
        if (!found) report_failure("timeout: no rising edge on scan2x_hs");
    endtask

    task automatic check_line();
        logic [3*OUT_W-1:0] exp_pix;
        bit                 ok;
        bit                 rep_line;
        bit                 shown;
        bit                 cut;
        int                 base;
        sl_mode_e           mode;
        if (line_cnt != seen_line) begin
            if (seen_line >= 1 && line_cnt == seen_line + 1 && rises_in_line != 2)
                report_failure("an input line did not give exactly two output lines");
            seen_line     = line_cnt;
            rises_in_line = 0;
        end
        rises_in_line++;
        if (line_cnt >= 1 && rises_in_line > 2)
            report_failure("more than two output lines for one input line");
        if (line_cnt >= 1 && rises_in_line == 2)
            compare_value("scan2x_hs period", HLEN, out_tick - last_rise_tick);
        last_rise_tick = out_tick;
        rep_line = rises_in_line == 2;
        shown    = line_cnt >= 2;
        mode     = sl_mode;
        // Address 0 holds the pixel after the line start tick of the stored line
        base     = shown ? starts[line_cnt-2] + 1 : 0;
        cut      = 1'b0;
        for (int n = 0; n < HLEN; n++) begin
            if (n > 0) begin
                next_out_tick(ok);
                if (!ok) return;
            end
            exp_pix = shown ? expected_pixel(pix_stream[base+n], rep_line, mode) : '0;
            compare_value("scan2x_r", exp_pix[3*OUT_W-1 -: OUT_W], scan2x_r);
            compare_value("scan2x_g", exp_pix[2*OUT_W-1 -: OUT_W], scan2x_g);
            compare_value("scan2x_b", exp_pix[OUT_W-1:0], scan2x_b);
            compare_value("scan2x_hs", n < HS_LEN, scan2x_hs);
            // A line start sends the read position back to 0 two ticks later
            if (cut && n < HLEN - 1) return;
            cut = line_cnt != seen_line;
        end
        if (shown) shown_lines++;
    endtask

    initial begin : compare
        forever begin
            wait_rise();
            check_line();
        end
    end

    initial begin : stimulus
        sl_mode_e modes[3];
        modes       = '{SL_25, SL_50, SL_75};
        clk_sys     = 1'b0;
        reset       = 1'b1;
        pxl_cen     = 1'b0;
        pxl2_cen    = 1'b0;
        base_pxl    = '0;
        hs          = 1'b0;
        sl_mode     = SL_NONE;
        line_cnt    = 0;
        out_tick    = 0;
        seen_line   = 0;
        shown_lines = 0;
        void'($urandom(SEED));
        @(negedge clk_sys);
        apply_reset();
        run_idle(IDLE_TICKS);
        repeat (4) run_line(SL_NONE);
        foreach (modes[m]) begin
            repeat (3) run_line(modes[m]);
        end
        // Ping-pong run with fresh random lines
        repeat (20) run_line(SL_NONE);
        apply_reset();
        run_idle(IDLE_TICKS);
        repeat (4) run_line(SL_NONE);
        // One more pixel closes the last repeat line
        drive_pixel(1'b0, DW'($urandom));
        repeat (4) @(negedge clk_sys);
        if (shown_lines >= MIN_SHOWN) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            $display("only %0d output lines with pixels were compared", shown_lines);
            report_failure("too few output lines compared");
        end
    end

endmodule

`default_nettype wire
